//--- design/pss_sync_pkg.sv
package pss_sync_pkg;

    // width of one I or Q component.
    localparam int SAMPLE_W = 16;

    // width of the squared-magnitude correlation value.
    localparam int CORR_W = 48;

    typedef struct packed {
        logic signed [SAMPLE_W-1:0] i;
        logic signed [SAMPLE_W-1:0] q;
    } iq_sample_t;

    // full-rate or decimated sample stream beat.
    typedef struct packed {
        logic       valid;
        iq_sample_t sample;
    } iq_beat_t;

    typedef struct packed {
        logic              valid;
        logic [CORR_W-1:0] value;
    } corr_beat_t;

    // gated symbol beat, first and last mark the ends of the symbol.
    typedef struct packed {
        logic       valid;
        logic       first;
        logic       last;
        iq_sample_t sample;
    } symbol_beat_t;

    typedef enum logic [1:0] {
        GATE_IDLE,
        GATE_WAIT,
        GATE_PASS
    } gate_state_e;

endpackage

//--- design/cic_decimator.sv
`timescale 1ns/100ps

module cic_decimator (
    input  logic                   clk_i,
    input  logic                   reset_ni,
    input  pss_sync_pkg::iq_beat_t in_i,
    output pss_sync_pkg::iq_beat_t out_o
);

    localparam int N_STAGES   = 3;
    localparam int GAIN_SHIFT = 3;
    localparam int INT_W      = pss_sync_pkg::SAMPLE_W + GAIN_SHIFT;

    // index 0 is the I component, index 1 the Q component.
    logic signed [pss_sync_pkg::SAMPLE_W-1:0] comp_in [2];
    logic signed [INT_W-1:0]                  integ_q [2][N_STAGES];
    logic signed [INT_W-1:0]                  integ_d [2][N_STAGES];
    logic signed [INT_W-1:0]                  comb_dly_q [2][N_STAGES];
    logic signed [INT_W-1:0]                  comb [2][N_STAGES+1];
    logic signed [INT_W-1:0]                  scaled [2];

    logic                     phase_q;
    logic                     valid_q;
    pss_sync_pkg::iq_sample_t sample_q;

    assign comp_in[0] = in_i.sample.i;
    assign comp_in[1] = in_i.sample.q;

    // the integrators and combs see the current beat in the same cycle,
    // so the decimated sample leaves one cycle after the second beat.
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            integ_d[c][0] = integ_q[c][0] + INT_W'(comp_in[c]);
            for (int k = 1; k < N_STAGES; k++) begin
                integ_d[c][k] = integ_q[c][k] + integ_d[c][k-1];
            end
            comb[c][0] = integ_d[c][N_STAGES-1];
            for (int k = 0; k < N_STAGES; k++) begin
                comb[c][k+1] = comb[c][k] - comb_dly_q[c][k];
            end
            // gain of the filter is (R*M)^N = 8.
            scaled[c] = comb[c][N_STAGES] >>> GAIN_SHIFT;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            phase_q    <= 1'b0;
            valid_q    <= 1'b0;
            integ_q    <= '{default: '0};
            comb_dly_q <= '{default: '0};
        end else begin
            valid_q <= in_i.valid && phase_q;
            if (in_i.valid) begin
                phase_q <= ~phase_q;
                integ_q <= integ_d;
                if (phase_q) begin
                    for (int c = 0; c < 2; c++) begin
                        for (int k = 0; k < N_STAGES; k++) begin
                            comb_dly_q[c][k] <= comb[c][k];
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_i.valid && phase_q) begin
            sample_q.i <= scaled[0][pss_sync_pkg::SAMPLE_W-1:0];
            sample_q.q <= scaled[1][pss_sync_pkg::SAMPLE_W-1:0];
        end
    end

    assign out_o.valid  = valid_q;
    assign out_o.sample = sample_q;

endmodule

//--- design/pss_correlator.sv
`timescale 1ns/100ps

module pss_correlator #(
    parameter int                 PSS_LEN  = 16,
    parameter logic [PSS_LEN-1:0] PSS_TAPS = '0
) (
    input  logic                     clk_i,
    input  logic                     reset_ni,
    input  pss_sync_pkg::iq_beat_t   in_i,
    output pss_sync_pkg::corr_beat_t out_o
);

    // one extra bit covers the full negative sample times PSS_LEN.
    localparam int SUM_W = pss_sync_pkg::SAMPLE_W + $clog2(PSS_LEN) + 1;

    // the window is the incoming sample followed by the stored history,
    // so the history holds one entry less than the tap count.
    pss_sync_pkg::iq_sample_t win [PSS_LEN];
    pss_sync_pkg::iq_sample_t hist_q [PSS_LEN-1];

    logic signed [SUM_W-1:0]                sum_i_d;
    logic signed [SUM_W-1:0]                sum_q_d;
    logic signed [SUM_W-1:0]                sum_i_q;
    logic signed [SUM_W-1:0]                sum_q_q;
    logic        [pss_sync_pkg::CORR_W-1:0] sq_i;
    logic        [pss_sync_pkg::CORR_W-1:0] sq_q;
    logic        [pss_sync_pkg::CORR_W-1:0] power_q;
    logic                                   sum_valid_q;
    logic                                   power_valid_q;

    always_comb begin
        win[0] = in_i.sample;
        for (int k = 1; k < PSS_LEN; k++) begin
            win[k] = hist_q[k-1];
        end
    end

    // a tap bit of 1 stands for -1, so that sample is subtracted.
    always_comb begin
        sum_i_d = '0;
        sum_q_d = '0;
        for (int k = 0; k < PSS_LEN; k++) begin
            if (PSS_TAPS[k]) begin
                sum_i_d = sum_i_d - SUM_W'(win[k].i);
                sum_q_d = sum_q_d - SUM_W'(win[k].q);
            end else begin
                sum_i_d = sum_i_d + SUM_W'(win[k].i);
                sum_q_d = sum_q_d + SUM_W'(win[k].q);
            end
        end
    end

    // the squares are formed at the full output width.
    assign sq_i = sum_i_q * sum_i_q;
    assign sq_q = sum_q_q * sum_q_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            hist_q        <= '{default: '0};
            sum_valid_q   <= 1'b0;
            power_valid_q <= 1'b0;
        end else begin
            sum_valid_q   <= in_i.valid;
            power_valid_q <= sum_valid_q;
            if (in_i.valid) begin
                for (int k = 0; k < PSS_LEN-1; k++) begin
                    hist_q[k] <= win[k];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_i.valid) begin
            sum_i_q <= sum_i_d;
            sum_q_q <= sum_q_d;
        end
        if (sum_valid_q) begin
            power_q <= sq_i + sq_q;
        end
    end

    assign out_o.valid = power_valid_q;
    assign out_o.value = power_q;

endmodule

//--- design/peak_detector.sv
`timescale 1ns/100ps

module peak_detector #(
    parameter int WINDOW_LEN = 8
) (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  pss_sync_pkg::corr_beat_t          in_i,
    input  logic [pss_sync_pkg::CORR_W-1:0]   threshold_i,
    output logic                              peak_o
);

    // hist_q[0] is the most recent of the stored values.
    logic [pss_sync_pkg::CORR_W-1:0] hist_q [WINDOW_LEN];
    logic                            beats_hist;
    logic                            is_peak;
    logic                            peak_q;

    always_comb begin
        beats_hist = 1'b1;
        for (int k = 0; k < WINDOW_LEN; k++) begin
            if (in_i.value <= hist_q[k]) begin
                beats_hist = 1'b0;
            end
        end
    end

    assign is_peak = in_i.valid && (in_i.value > threshold_i) && beats_hist;

    // the new value enters the history after it has been judged.
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            peak_q <= 1'b0;
            hist_q <= '{default: '0};
        end else begin
            peak_q <= is_peak;
            if (in_i.valid) begin
                hist_q[0] <= in_i.value;
                for (int k = 1; k < WINDOW_LEN; k++) begin
                    hist_q[k] <= hist_q[k-1];
                end
            end
        end
    end

    assign peak_o = peak_q;

endmodule

//--- design/symbol_gate.sv
`timescale 1ns/100ps

module symbol_gate #(
    parameter int WAIT_LEN   = 20,
    parameter int SYMBOL_LEN = 32
) (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  pss_sync_pkg::iq_beat_t     in_i,
    input  logic                       peak_i,
    output pss_sync_pkg::symbol_beat_t out_o
);

    localparam int MAX_LEN = (WAIT_LEN > SYMBOL_LEN) ? WAIT_LEN : SYMBOL_LEN;
    localparam int CNT_W   = $clog2(MAX_LEN + 1);

    pss_sync_pkg::gate_state_e state_q;
    logic [CNT_W-1:0]          count_q;
    logic                      wait_done;
    logic                      pass_last;
    logic                      valid_q;
    logic                      first_q;
    logic                      last_q;
    pss_sync_pkg::iq_sample_t  sample_q;

    assign wait_done = (count_q == CNT_W'(WAIT_LEN - 1));
    assign pass_last = (count_q == CNT_W'(SYMBOL_LEN - 1));

    // the beat in the peak cycle itself is not counted, since the gate
    // only starts counting once it sits in GATE_WAIT.
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= pss_sync_pkg::GATE_IDLE;
            count_q <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                pss_sync_pkg::GATE_IDLE: begin
                    count_q <= '0;
                    if (peak_i) begin
                        state_q <= pss_sync_pkg::GATE_WAIT;
                    end
                end
                pss_sync_pkg::GATE_WAIT: begin
                    if (in_i.valid) begin
                        if (wait_done) begin
                            count_q <= '0;
                            state_q <= pss_sync_pkg::GATE_PASS;
                        end else begin
                            count_q <= count_q + 1'b1;
                        end
                    end
                end
                pss_sync_pkg::GATE_PASS: begin
                    if (in_i.valid) begin
                        valid_q <= 1'b1;
                        if (pass_last) begin
                            count_q <= '0;
                            state_q <= pss_sync_pkg::GATE_IDLE;
                        end else begin
                            count_q <= count_q + 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= pss_sync_pkg::GATE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_i.valid && state_q == pss_sync_pkg::GATE_PASS) begin
            first_q  <= (count_q == '0);
            last_q   <= pass_last;
            sample_q <= in_i.sample;
        end
    end

    assign out_o.valid  = valid_q;
    assign out_o.first  = first_q;
    assign out_o.last   = last_q;
    assign out_o.sample = sample_q;

endmodule

//--- design/pss_sync_top.sv
`timescale 1ns/100ps

module pss_sync_top #(
    parameter int                 PSS_LEN    = 16,
    parameter logic [PSS_LEN-1:0] PSS_TAPS   = 16'b0110_1011_0001_1100,
    parameter int                 WINDOW_LEN = 8,
    parameter int                 WAIT_LEN   = 20,
    parameter int                 SYMBOL_LEN = 32
) (
    input  logic                            clk_i,
    input  logic                            reset_ni,
    input  pss_sync_pkg::iq_beat_t          in_i,
    input  logic [pss_sync_pkg::CORR_W-1:0] threshold_i,
    output pss_sync_pkg::iq_beat_t          decim_o,
    output pss_sync_pkg::corr_beat_t        corr_o,
    output logic                            peak_o,
    output pss_sync_pkg::symbol_beat_t      symbol_o
);

    pss_sync_pkg::iq_beat_t   decim;
    pss_sync_pkg::corr_beat_t corr;
    logic                     peak;

    cic_decimator u_cic (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .in_i     (in_i),
        .out_o    (decim)
    );

    pss_correlator #(
        .PSS_LEN  (PSS_LEN),
        .PSS_TAPS (PSS_TAPS)
    ) u_corr (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .in_i     (decim),
        .out_o    (corr)
    );

    peak_detector #(
        .WINDOW_LEN (WINDOW_LEN)
    ) u_peak (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_i        (corr),
        .threshold_i (threshold_i),
        .peak_o      (peak)
    );

    // the gate works on the full-rate input, not on the decimated stream.
    symbol_gate #(
        .WAIT_LEN   (WAIT_LEN),
        .SYMBOL_LEN (SYMBOL_LEN)
    ) u_gate (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .in_i     (in_i),
        .peak_i   (peak),
        .out_o    (symbol_o)
    );

    assign decim_o = decim;
    assign corr_o  = corr;
    assign peak_o  = peak;

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic reset_no
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // reset is released on a falling edge, away from the sampling edge.
    initial begin
        reset_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_no = 1'b1;
    end

endmodule

//--- testbench/tb_pss_sync.sv
`timescale 1ns/100ps

module tb_pss_sync;

    localparam int                 PSS_LEN    = 16;
    localparam logic [PSS_LEN-1:0] PSS_TAPS   = 16'b0110_1011_0001_1100;
    localparam int                 WINDOW_LEN = 8;
    localparam int                 WAIT_LEN   = 20;
    localparam int                 SYMBOL_LEN = 32;
    localparam int                 PSS_AMP    = 4000;
    localparam logic [47:0]        DET_LEVEL  = 48'd1_000_000_000;

    logic                                clk;
    logic                                gen_rst_n;
    logic                                test_rst_n;
    logic                                reset_n;
    pss_sync_pkg::iq_beat_t              in_beat;
    logic [pss_sync_pkg::CORR_W-1:0]     threshold;
    pss_sync_pkg::iq_beat_t              decim_o;
    pss_sync_pkg::corr_beat_t            corr_o;
    logic                                peak_o;
    pss_sync_pkg::symbol_beat_t          symbol_o;

    // reference model state, kept apart from the DUT.
    int                                  integ [2][3];
    int                                  comb_dly [2][3];
    logic                                phase;
    pss_sync_pkg::iq_sample_t            line [PSS_LEN];
    logic [47:0]                         win_hist [WINDOW_LEN];
    pss_sync_pkg::gate_state_e           gate_state;
    int                                  gate_cnt;
    logic                                peak_pending;
    pss_sync_pkg::iq_sample_t            exp_decim [$];
    logic [47:0]                         exp_corr [$];
    pss_sync_pkg::symbol_beat_t          exp_sym [$];

    int n_in, n_decim, n_corr, n_peak, n_win, exp_win;
    int e_decim, e_corr, e_peak, e_sym, e_rst;
    int tests_run, tests_failed, total_errs;
    logic [31:0] rng;

    assign reset_n = gen_rst_n & test_rst_n;

    tb_clock_gen u_clk (
        .clk_o    (clk),
        .reset_no (gen_rst_n)
    );

    pss_sync_top #(
        .PSS_LEN    (PSS_LEN),
        .PSS_TAPS   (PSS_TAPS),
        .WINDOW_LEN (WINDOW_LEN),
        .WAIT_LEN   (WAIT_LEN),
        .SYMBOL_LEN (SYMBOL_LEN)
    ) u_dut (
        .clk_i       (clk),
        .reset_ni    (reset_n),
        .in_i        (in_beat),
        .threshold_i (threshold),
        .decim_o     (decim_o),
        .corr_o      (corr_o),
        .peak_o      (peak_o),
        .symbol_o    (symbol_o)
    );

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic void reset_models();
        integ        = '{default: 0};
        comb_dly     = '{default: 0};
        phase        = 1'b0;
        line         = '{default: '0};
        win_hist     = '{default: '0};
        gate_state   = pss_sync_pkg::GATE_IDLE;
        gate_cnt     = 0;
        peak_pending = 1'b0;
        exp_decim.delete();
        exp_corr.delete();
        exp_sym.delete();
    endfunction

    // third-order CIC, rate two, unit delay, output divided by its gain of 8.
    function automatic bit cic_model(input pss_sync_pkg::iq_sample_t s,
                                     output pss_sync_pkg::iq_sample_t y);
        int x [2];
        int acc;
        int diff;
        x[0] = s.i;
        x[1] = s.q;
        y = '0;
        for (int c = 0; c < 2; c++) begin
            integ[c][0] += x[c];
            integ[c][1] += integ[c][0];
            integ[c][2] += integ[c][1];
        end
        phase = ~phase;
        if (phase) begin
            return 1'b0;
        end
        for (int c = 0; c < 2; c++) begin
            acc = integ[c][2];
            for (int k = 0; k < 3; k++) begin
                diff = acc - comb_dly[c][k];
                comb_dly[c][k] = acc;
                acc = diff;
            end
            acc = acc >>> 3;
            if (c == 0) y.i = acc[15:0];
            else y.q = acc[15:0];
        end
        return 1'b1;
    endfunction

    function automatic logic [47:0] corr_model(input pss_sync_pkg::iq_sample_t s);
        longint si;
        longint sq;
        for (int k = PSS_LEN - 1; k > 0; k--) begin
            line[k] = line[k-1];
        end
        line[0] = s;
        si = 0;
        sq = 0;
        for (int k = 0; k < PSS_LEN; k++) begin
            if (PSS_TAPS[k]) begin
                si -= line[k].i;
                sq -= line[k].q;
            end else begin
                si += line[k].i;
                sq += line[k].q;
            end
        end
        return 48'(si * si + sq * sq);
    endfunction

    function automatic logic peak_model(input logic [47:0] v);
        logic p;
        p = (v > threshold);
        for (int k = 0; k < WINDOW_LEN; k++) begin
            if (v <= win_hist[k]) p = 1'b0;
        end
        for (int k = WINDOW_LEN - 1; k > 0; k--) begin
            win_hist[k] = win_hist[k-1];
        end
        win_hist[0] = v;
        return p;
    endfunction

    // one cycle of the gate window; a beat in the peak cycle is not counted.
    function automatic void gate_model(input logic peak, input pss_sync_pkg::iq_beat_t b);
        pss_sync_pkg::symbol_beat_t e;
        case (gate_state)
            pss_sync_pkg::GATE_IDLE: begin
                if (peak) begin
                    gate_state = pss_sync_pkg::GATE_WAIT;
                    gate_cnt = 0;
                end
            end
            pss_sync_pkg::GATE_WAIT: begin
                if (b.valid) begin
                    gate_cnt++;
                    if (gate_cnt == WAIT_LEN) begin
                        gate_state = pss_sync_pkg::GATE_PASS;
                        gate_cnt = 0;
                        exp_win++;
                    end
                end
            end
            default: begin
                if (b.valid) begin
                    e.valid = 1'b1;
                    e.first = (gate_cnt == 0);
                    e.last = (gate_cnt == SYMBOL_LEN - 1);
                    e.sample = b.sample;
                    exp_sym.push_back(e);
                    gate_cnt++;
                    if (gate_cnt == SYMBOL_LEN) gate_state = pss_sync_pkg::GATE_IDLE;
                end
            end
        endcase
    endfunction

    always @(posedge clk) begin : compare
        pss_sync_pkg::iq_sample_t   y;
        pss_sync_pkg::symbol_beat_t e;
        logic [47:0]                c;
        if (!reset_n) begin
            reset_models();
        end else begin
            if (symbol_o.valid) begin
                if (symbol_o.first) n_win++;
                assert (exp_sym.size() > 0) else begin
                    $display("symbol_o delivered a beat outside any expected window");
                    e_sym++;
                end
                if (exp_sym.size() > 0) begin
                    e = exp_sym.pop_front();
                    assert (symbol_o == e) else begin
                        $display("[ERROR] symbol_o expected %h actual %h", e, symbol_o);
                        e_sym++;
                    end
                end
            end
            assert (peak_o == peak_pending) else begin
                $display("[ERROR] peak_o expected %h actual %h", peak_pending, peak_o);
                e_peak++;
            end
            if (peak_o) n_peak++;
            gate_model(peak_pending, in_beat);
            peak_pending = 1'b0;
            if (corr_o.valid) begin
                n_corr++;
                assert (exp_corr.size() > 0) else begin
                    $display("corr_o delivered a beat that was not expected");
                    e_corr++;
                end
                if (exp_corr.size() > 0) begin
                    c = exp_corr.pop_front();
                    assert (corr_o.value == c) else begin
                        $display("[ERROR] corr_o expected %h actual %h", c, corr_o.value);
                        e_corr++;
                    end
                    peak_pending = peak_model(c);
                end
            end
            if (decim_o.valid) begin
                n_decim++;
                assert (exp_decim.size() > 0) else begin
                    $display("decim_o delivered a beat that was not expected");
                    e_decim++;
                end
                if (exp_decim.size() > 0) begin
                    y = exp_decim.pop_front();
                    assert (decim_o.sample == y) else begin
                        $display("[ERROR] decim_o expected %h actual %h", y, decim_o.sample);
                        e_decim++;
                    end
                end
            end
            if (in_beat.valid) begin
                n_in++;
                if (cic_model(in_beat.sample, y)) begin
                    exp_decim.push_back(y);
                    exp_corr.push_back(corr_model(y));
                end
            end
        end
    end

    function automatic void clear_counts(input bit errors_too);
        n_in = 0;
        n_decim = 0;
        n_corr = 0;
        n_peak = 0;
        n_win = 0;
        exp_win = 0;
        if (errors_too) begin
            e_decim = 0;
            e_corr = 0;
            e_peak = 0;
            e_sym = 0;
            e_rst = 0;
        end
    endfunction

    // a random gap of zero to two idle cycles follows each beat.
    task automatic send_beat(input logic signed [15:0] si, input logic signed [15:0] sq);
        logic [31:0] r;
        @(negedge clk);
        in_beat.valid = 1'b1;
        in_beat.sample.i = si;
        in_beat.sample.q = sq;
        r = next_rand();
        repeat (r % 3) begin
            @(negedge clk);
            in_beat.valid = 1'b0;
        end
    endtask

    task automatic send_noise(input int n, input bit full_scale);
        logic [31:0] r;
        for (int k = 0; k < n; k++) begin
            r = next_rand();
            if (full_scale) send_beat(r[15:0], r[31:16]);
            else send_beat(16'($signed(r[8:0])), 16'($signed(r[24:16])));
        end
    endtask

    // each tap is held for two full-rate samples, oldest tap first.
    task automatic send_pss();
        logic signed [15:0] v;
        for (int k = PSS_LEN - 1; k >= 0; k--) begin
            v = PSS_TAPS[k] ? -16'(PSS_AMP) : 16'(PSS_AMP);
            send_beat(v, v);
            send_beat(v, v);
        end
    endtask

    task automatic stop_input();
        @(negedge clk);
        in_beat.valid = 1'b0;
    endtask

    task automatic drain(input string what);
        int cycles;
        cycles = 0;
        while (exp_decim.size() + exp_corr.size() + exp_sym.size() > 0 || peak_pending
               || gate_state != pss_sync_pkg::GATE_IDLE) begin
            if (cycles == 500) begin
                $display("timeout while draining the pipeline in the %s test", what);
                $display("TEST FAILED");
                $finish;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs);
        tests_run++;
        total_errs += errs;
        if (errs == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, errs);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual,
                               inout int errs);
        assert (expected == actual) else begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            errs++;
        end
    endtask

    initial begin : main
        int cycles;
        in_beat = '0;
        threshold = '1;
        test_rst_n = 1'b1;
        rng = 32'hfa4b;
        tests_run = 0;
        tests_failed = 0;
        total_errs = 0;
        reset_models();
        clear_counts(1'b1);
        cycles = 0;
        while (reset_n !== 1'b1) begin
            if (cycles == 20) begin
                $display("timeout waiting for reset release");
                $display("TEST FAILED");
                $finish;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end

        send_noise(200, 1'b1);
        stop_input();
        drain("decimation");
        check_count("decim_o beat count", n_in / 2, n_decim, e_decim);
        check_count("corr_o beat count", n_in / 2, n_corr, e_corr);
        check_count("peak_o pulse count", 0, n_peak, e_peak);
        report_test(1, "decimation", e_decim);
        report_test(2, "correlation", e_corr);
        report_test(3, "no peak at maximum threshold", e_peak);

        @(negedge clk);
        threshold = DET_LEVEL;
        clear_counts(1'b1);
        send_noise(20, 1'b0);
        send_pss();
        send_noise(10, 1'b0);
        send_pss();
        send_noise(80, 1'b0);
        send_pss();
        send_noise(80, 1'b0);
        stop_input();
        drain("symbol window");
        assert (n_peak > 0) else begin
            $display("no peak_o pulse followed the sync sequences");
            e_peak++;
        end
        check_count("symbol window count", exp_win, n_win, e_sym);
        assert (exp_win >= 2) else begin
            $display("the gate did not open a second window after returning to idle");
            e_sym++;
        end
        assert (n_peak > exp_win) else begin
            $display("no peak arrived while the gate was waiting or passing");
            e_sym++;
        end
        report_test(4, "peak detection", e_peak + e_decim + e_corr);
        report_test(5, "symbol window", e_sym);

        clear_counts(1'b1);
        send_noise(20, 1'b0);
        send_pss();
        cycles = 0;
        while (gate_state != pss_sync_pkg::GATE_PASS) begin
            if (cycles == 300) begin
                $display("timeout waiting for the gate to start passing samples");
                $display("TEST FAILED");
                $finish;
            end else begin
                send_noise(1, 1'b0);
                cycles++;
            end
        end
        send_noise(3, 1'b0);
        // input beats keep arriving while reset is held.
        @(negedge clk);
        in_beat.valid = 1'b1;
        test_rst_n = 1'b0;
        repeat (3) @(negedge clk);
        assert (!decim_o.valid && !corr_o.valid && !symbol_o.valid && !peak_o) else begin
            $display("outputs were not idle while reset was held");
            e_rst++;
        end
        in_beat.valid = 1'b0;
        test_rst_n = 1'b1;
        @(negedge clk);
        assert (!decim_o.valid && !corr_o.valid && !symbol_o.valid && !peak_o) else begin
            $display("outputs were not idle after reset release");
            e_rst++;
        end
        clear_counts(1'b0);
        send_noise(100, 1'b1);
        send_noise(20, 1'b0);
        send_pss();
        send_noise(80, 1'b0);
        stop_input();
        drain("reset");
        check_count("decim_o beat count", n_in / 2, n_decim, e_decim);
        check_count("symbol window count", exp_win, n_win, e_sym);
        assert (exp_win > 0) else begin
            $display("no symbol window opened after reset release");
            e_sym++;
        end
        report_test(6, "reset mid-stream", e_decim + e_corr + e_peak + e_sym + e_rst);

        $display("tests %0d failed %0d errors %0d", tests_run, tests_failed, total_errs);
        if (tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
design/pss_sync_pkg.sv
design/cic_decimator.sv
design/pss_correlator.sv
design/peak_detector.sv
design/symbol_gate.sv
design/pss_sync_top.sv
testbench/tb_clock_gen.sv
testbench/tb_pss_sync.sv
